/* hw/sram_lane_pkg.sv */
`default_nettype none

package sram_lane_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int data_width      = 16;  // apb data word
    localparam int word_width      = 32;  // macro word
    localparam int lane_width      = 8;
    localparam int word_addr_width = 10;  // 1024 words per macro
    localparam int bank_sel_width  = 3;

    localparam int num_banks = 7;  // bank 7 does not exist

    // bank number on top, word address below
    localparam int addr_width = bank_sel_width + word_addr_width;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane layout per bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // lane index of the high byte, bank 0 first
    localparam int unsigned hi_lane [num_banks] = '{1, 3, 3, 3, 2, 2, 1};

    // lane index of the low byte
    localparam int unsigned lo_lane [num_banks] = '{0, 0, 2, 1, 0, 1, 0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // apb port fsm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        idle,    // waiting for setup phase
        access,  // macro access issued
        done     // pready high
    } apb_state_t;

endpackage

`default_nettype wire

/* hw/macro_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module macro_sram (
    input  logic                                    clk,
    input  logic                                    en,
    input  logic                                    we,
    input  logic [sram_lane_pkg::word_addr_width-1:0] addr,
    input  logic [sram_lane_pkg::word_width-1:0]      din,
    output logic [sram_lane_pkg::word_width-1:0]      dout
);

    logic [sram_lane_pkg::word_width-1:0] mem [2**sram_lane_pkg::word_addr_width];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];  // held until next read
            end
        end
    end

    // an x on the address would corrupt an unknown word
    addr_known_a: assert property (
        @(posedge clk) en |-> !$isunknown(addr)
    );

endmodule

`default_nettype wire

/* hw/bank_array.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_array (
    input  logic                                      clk,
    input  logic                                      mem_en,
    input  logic                                      mem_we,
    input  logic [sram_lane_pkg::bank_sel_width-1:0]  bank_sel,
    input  logic [sram_lane_pkg::word_addr_width-1:0] word_addr,
    input  logic [sram_lane_pkg::data_width-1:0]      wdata,
    output logic [sram_lane_pkg::num_banks-1:0][sram_lane_pkg::word_width-1:0] rdata_words
);

    localparam int lw = sram_lane_pkg::lane_width;
    localparam int dw = sram_lane_pkg::data_width;

    logic [sram_lane_pkg::num_banks-1:0] bank_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one macro per bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar b = 0; b < sram_lane_pkg::num_banks; b++) begin : g_bank
        logic [sram_lane_pkg::word_width-1:0] din;

        assign bank_en[b] = mem_en && (int'(bank_sel) == b);

        // unused lanes stay zero
        always_comb begin
            din = '0;
            din[sram_lane_pkg::hi_lane[b]*lw +: lw] = wdata[dw-1 -: lw];
            din[sram_lane_pkg::lo_lane[b]*lw +: lw] = wdata[lw-1:0];
        end

        macro_sram sram_i (
            .clk  (clk),
            .en   (bank_en[b]),
            .we   (mem_we),
            .addr (word_addr),
            .din  (din),
            .dout (rdata_words[b])
        );
    end

    // each access opens exactly one macro, so bank 7 never gets here
    one_bank_a: assert property (
        @(posedge clk) mem_en |-> $onehot(bank_en)
    );

endmodule

`default_nettype wire

/* hw/read_lane_select.sv */
`timescale 1ns/1ns
`default_nettype none

module read_lane_select (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     mem_en,
    input  logic                                     mem_we,
    input  logic [sram_lane_pkg::bank_sel_width-1:0] bank_sel,
    input  logic [sram_lane_pkg::num_banks-1:0][sram_lane_pkg::word_width-1:0] rdata_words,
    output logic [sram_lane_pkg::data_width-1:0]     rdata
);

    localparam int lw = sram_lane_pkg::lane_width;

    logic [sram_lane_pkg::bank_sel_width-1:0] rd_bank;  // bank of last read

    // lines up with the macro output one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bank <= '0;
        end else if (mem_en && !mem_we) begin
            rd_bank <= bank_sel;
        end
    end

    always_comb begin
        rdata = '0;
        for (int b = 0; b < sram_lane_pkg::num_banks; b++) begin
            if (int'(rd_bank) == b) begin
                rdata = {rdata_words[b][sram_lane_pkg::hi_lane[b]*lw +: lw],
                         rdata_words[b][sram_lane_pkg::lo_lane[b]*lw +: lw]};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/apb_mem_port.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_mem_port (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [sram_lane_pkg::addr_width-1:0]      paddr,
    input  logic [sram_lane_pkg::data_width-1:0]      pwdata,
    input  logic [sram_lane_pkg::data_width-1:0]      rdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic [sram_lane_pkg::data_width-1:0]      prdata,
    output logic                                      mem_en,
    output logic                                      mem_we,
    output logic [sram_lane_pkg::bank_sel_width-1:0]  bank_sel,
    output logic [sram_lane_pkg::word_addr_width-1:0] word_addr,
    output logic [sram_lane_pkg::data_width-1:0]      wdata
);

    sram_lane_pkg::apb_state_t state;
    logic                      bank_ok;

    // master holds these until pready
    assign bank_sel  = paddr[sram_lane_pkg::addr_width-1 -: sram_lane_pkg::bank_sel_width];
    assign word_addr = paddr[sram_lane_pkg::word_addr_width-1:0];
    assign mem_we    = pwrite;
    assign wdata     = pwdata;

    assign bank_ok = int'(bank_sel) < sram_lane_pkg::num_banks;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer fsm, one wait state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= sram_lane_pkg::idle;
            mem_en  <= 1'b0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            mem_en  <= 1'b0;  // single-cycle pulses
            pready  <= 1'b0;
            pslverr <= 1'b0;
            case (state)
                sram_lane_pkg::idle: begin
                    if (psel && !penable) begin  // setup phase
                        state  <= sram_lane_pkg::access;
                        mem_en <= bank_ok;  // bad bank never reaches a macro
                    end
                end
                sram_lane_pkg::access: begin
                    state   <= sram_lane_pkg::done;
                    pready  <= 1'b1;
                    pslverr <= !bank_ok;
                end
                sram_lane_pkg::done: begin
                    state <= sram_lane_pkg::idle;
                end
                default: begin
                    state <= sram_lane_pkg::idle;
                end
            endcase
        end
    end

    // macro output is valid in the done cycle
    assign prdata = (pready && !pslverr && !pwrite) ? rdata : '0;

    penable_needs_psel_a: assert property (
        @(posedge clk) disable iff (reset) $rose(penable) |-> psel
    );

endmodule

`default_nettype wire

/* hw/sram_lane_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_lane_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [sram_lane_pkg::addr_width-1:0] paddr,
    input  logic [sram_lane_pkg::data_width-1:0] pwdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [sram_lane_pkg::data_width-1:0] prdata
);

    logic                                      mem_en;
    logic                                      mem_we;
    logic [sram_lane_pkg::bank_sel_width-1:0]  bank_sel;
    logic [sram_lane_pkg::word_addr_width-1:0] word_addr;
    logic [sram_lane_pkg::data_width-1:0]      wdata;
    logic [sram_lane_pkg::data_width-1:0]      rdata;
    logic [sram_lane_pkg::num_banks-1:0][sram_lane_pkg::word_width-1:0] rdata_words;

    apb_mem_port port_i (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .rdata     (rdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .prdata    (prdata),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .bank_sel  (bank_sel),
        .word_addr (word_addr),
        .wdata     (wdata)
    );

    bank_array banks_i (
        .clk         (clk),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .bank_sel    (bank_sel),
        .word_addr   (word_addr),
        .wdata       (wdata),
        .rdata_words (rdata_words)
    );

    read_lane_select rsel_i (
        .clk         (clk),
        .reset       (reset),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .bank_sel    (bank_sel),
        .rdata_words (rdata_words),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

/* bench/tb_sram_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sram_lane;

    localparam int total_transfers = 14 + 400 + 3;  // tests 2, 3 and 4
    localparam int cycle_limit     = 4 * total_transfers * 3 + 100;

    logic                                 clk;
    logic                                 reset;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [sram_lane_pkg::addr_width-1:0] paddr;
    logic [sram_lane_pkg::data_width-1:0] pwdata;
    logic                                 pready;
    logic                                 pslverr;
    logic [sram_lane_pkg::data_width-1:0] prdata;

    logic [sram_lane_pkg::data_width-1:0] model_mem [sram_lane_pkg::num_banks][1024];
    bit                                   written [sram_lane_pkg::num_banks][1024];
    logic [sram_lane_pkg::bank_sel_width-1:0]  q_bank [$];  // locations of test 3
    logic [sram_lane_pkg::word_addr_width-1:0] q_word [$];

    logic [31:0] rng_state = 32'd85831;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_ok;
    int          cycles;
    int          valid_err_count;  // valid transfers answered with pslverr

    sram_lane_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: failed", num, name);
        end
    endtask

    // setup, access, then wait for pready sampled at the falling edge
    task automatic apb_transfer(
        input  logic                                      write,
        input  logic [sram_lane_pkg::bank_sel_width-1:0]  bank,
        input  logic [sram_lane_pkg::word_addr_width-1:0] word,
        input  logic [sram_lane_pkg::data_width-1:0]      data,
        output logic [sram_lane_pkg::data_width-1:0]      read_value,
        output logic                                      error
    );
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= {bank, word};
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        read_value = prdata;
        error      = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_checked(
        input logic [sram_lane_pkg::bank_sel_width-1:0]  bank,
        input logic [sram_lane_pkg::word_addr_width-1:0] word,
        input logic [sram_lane_pkg::data_width-1:0]      data
    );
        logic [sram_lane_pkg::data_width-1:0] rd;
        logic                                 err;
        logic                                 bad_bank;
        bad_bank = int'(bank) >= sram_lane_pkg::num_banks;
        apb_transfer(1'b1, bank, word, data, rd, err);
        check_value("pslverr", 32'(bad_bank), 32'(err));
        if (!bad_bank) begin
            if (err) valid_err_count++;
            model_mem[bank][word] = data;
            written[bank][word]   = 1'b1;
        end
    endtask

    task automatic read_checked(
        input logic [sram_lane_pkg::bank_sel_width-1:0]  bank,
        input logic [sram_lane_pkg::word_addr_width-1:0] word
    );
        logic [sram_lane_pkg::data_width-1:0] rd;
        logic [sram_lane_pkg::data_width-1:0] expected;
        logic                                 err;
        logic                                 bad_bank;
        bad_bank = int'(bank) >= sram_lane_pkg::num_banks;
        expected = '0;  // bad bank reads back zero
        if (!bad_bank) begin
            if (!written[bank][word]) begin
                $display("read issued to unwritten location bank %0d word %0d", bank, word);
                errors++;
            end
            expected = model_mem[bank][word];
        end
        apb_transfer(1'b0, bank, word, 16'h0000, rd, err);
        check_value("pslverr", 32'(bad_bank), 32'(err));
        check_value("prdata", 32'(expected), 32'(rd));
        if (!bad_bank && err) valid_err_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0]                               r;
        logic [sram_lane_pkg::data_width-1:0]      vals [sram_lane_pkg::num_banks];
        logic [sram_lane_pkg::word_addr_width-1:0] word;
        logic [sram_lane_pkg::bank_sel_width-1:0]  bank;
        int                                        start;

        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        tests_ok        = 0;
        cycles          = 0;
        valid_err_count = 0;
        reset   <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start = errors;
        @(negedge clk);
        check_value("pready", 32'(0), 32'(pready));
        check_value("pslverr", 32'(0), 32'(pslverr));
        report_test(1, "idle after reset", start);

        start = errors;
        r    = next_random();
        word = 10'(r);
        for (int b = 0; b < sram_lane_pkg::num_banks; b++) begin
            r       = next_random();
            vals[b] = 16'(r);
            write_checked(3'(b), word, vals[b]);
        end
        for (int b = 0; b < sram_lane_pkg::num_banks; b++) begin
            read_checked(3'(b), word);
        end
        report_test(2, "every bank same word", start);

        start = errors;
        for (int i = 0; i < 200; i++) begin
            r    = next_random();
            bank = 3'(r % 7);
            word = 10'(r >> 16);
            r    = next_random();
            write_checked(bank, word, 16'(r));
            q_bank.push_back(bank);
            q_word.push_back(word);
        end
        foreach (q_bank[i]) begin
            read_checked(q_bank[i], q_word[i]);
        end
        report_test(3, "random writes and reads", start);

        start = errors;
        r = next_random();
        write_checked(3'd7, 10'(r), 16'(r >> 8));
        read_checked(3'd7, 10'(r));
        read_checked(q_bank[0], q_word[0]);  // array untouched by the bad bank
        report_test(4, "invalid bank 7", start);

        start = errors;
        check_value("valid transfers with pslverr", 32'(0), 32'(valid_err_count));
        report_test(5, "valid transfers error free", start);

        $display("%0d of %0d tests ok, %0d checks, %0d errors",
                 tests_ok, tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/sram_lane_pkg.sv
hw/macro_sram.sv
hw/bank_array.sv
hw/read_lane_select.sv
hw/apb_mem_port.sv
hw/sram_lane_top.sv
bench/tb_sram_lane.sv

/* Makefile */
TOP = tb_sram_lane

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
